// File: sources.f
hsid_pkg.sv
hsid_scan_if.sv
hsid_band_counter.sv
hsid_ctrl_fsm.sv
hsid_spec_mem.sv
hsid_mse_calc.sv
hsid_mse_comp.sv
hsid_top.sv
tb_hsid.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_hsid -f sources.f -o sim_hsid
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_hsid
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation passed"
exit 0

// File: tb_hsid.sv
module tb_hsid import hsid_pkg::*; ();

  localparam int RUN_CYCLES = LIB_SIZE * BANDS + 6;                // Start ack to done
  localparam int TIMEOUT_CYCLES = 2 * (6 * RUN_CYCLES + 700 * 3);  // Six runs and bus traffic
  localparam logic [31:0] SEED = 32'haa12_6e59;

  logic                clk = 1'b0;
  logic                rst_n = 1'b0;
  logic                wb_cyc = 1'b0;
  logic                wb_stb = 1'b0;
  logic                wb_we = 1'b0;
  logic [WB_ADR_W-1:0] wb_adr = '0;
  logic [WB_DAT_W-1:0] wb_dat_w = '0;
  logic [WB_DAT_W-1:0] wb_dat_r;
  logic                wb_ack;

  sample_t pix [BANDS];               // Pixel as loaded into the DUT
  sample_t lib [LIB_SIZE * BANDS];    // Library in entry major order
  int      cycle_cnt = 0;

  always #2 clk = ~clk;

  hsid_top hsid_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing", cycle_cnt);
      $display("Errors found");
      $fatal(1, "Timeout");
    end
  end

  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] wdata,
                           output logic [WB_DAT_W-1:0] rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);  // Ack seen mid cycle
    rdata = wb_dat_r;                // Valid alongside ack
    @(negedge clk);                  // Hold through the commit edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] data);
    logic [WB_DAT_W-1:0] ignored;
    wb_access(1'b1, adr, data, ignored);
  endtask

  task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic check_mse(input string name, input mse_t exp_v, input mse_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp_v, act_v);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_ref(input string name, input ref_t exp_v, input ref_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp_v, act_v);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_status(input logic [1:0] exp_bits, input logic [WB_DAT_W-1:0] act_v);
    if (act_v !== WB_DAT_W'(exp_bits)) begin   // Bit 1 done, bit 0 busy
      $display("ERR status expected 0x%h actual 0x%h", WB_DAT_W'(exp_bits), act_v);
      $display("Errors found");
      $fatal(1, "Mismatch on status");
    end
  endtask

  // Truncated mean of squared differences with later entries winning ties
  function automatic void ref_mse(output mse_t min_v, output ref_t min_r,
                                  output mse_t max_v, output ref_t max_r);
    mse_t sum;
    int   diff;
    min_v = {MSE_W{1'b1}};
    min_r = '0;
    max_v = '0;
    max_r = '0;
    for (int r = 0; r < LIB_SIZE; r++) begin
      sum = '0;
      for (int b = 0; b < BANDS; b++) begin
        diff = int'(pix[b]) - int'(lib[r * BANDS + b]);
        sum  = sum + mse_t'(longint'(diff) * longint'(diff));
      end
      sum = sum / BANDS;
      if (sum <= min_v) begin
        min_v = sum;
        min_r = ref_t'(r);
      end
      if (sum >= max_v) begin
        max_v = sum;
        max_r = ref_t'(r);
      end
    end
  endfunction

  task automatic read_results(output mse_t min_v, output ref_t min_r,
                              output mse_t max_v, output ref_t max_r);
    logic [WB_DAT_W-1:0] lo;
    logic [WB_DAT_W-1:0] hi;
    logic [WB_DAT_W-1:0] rd;
    wb_read(ADR_MIN_LO, lo);
    wb_read(ADR_MIN_HI, hi);
    min_v = {hi[MSE_W-WB_DAT_W-1:0], lo};  // 40 bit value from two words
    wb_read(ADR_MIN_REF, rd);
    min_r = ref_t'(rd);
    wb_read(ADR_MAX_LO, lo);
    wb_read(ADR_MAX_HI, hi);
    max_v = {hi[MSE_W-WB_DAT_W-1:0], lo};
    wb_read(ADR_MAX_REF, rd);
    max_r = ref_t'(rd);
  endtask

  task automatic check_results();
    mse_t exp_min;
    mse_t exp_max;
    mse_t min_v;
    mse_t max_v;
    ref_t exp_min_r;
    ref_t exp_max_r;
    ref_t min_r;
    ref_t max_r;
    ref_mse(exp_min, exp_min_r, exp_max, exp_max_r);
    read_results(min_v, min_r, max_v, max_r);
    check_mse("min_value", exp_min, min_v);
    check_ref("min_ref", exp_min_r, min_r);
    check_mse("max_value", exp_max, max_v);
    check_ref("max_ref", exp_max_r, max_r);
  endtask

  task automatic load_spectra(input logic with_lib);
    for (int b = 0; b < BANDS; b++) begin
      wb_write(ADR_PIXEL + WB_ADR_W'(b), WB_DAT_W'(pix[b]));
    end
    for (int i = 0; i < LIB_SIZE * BANDS && with_lib; i++) begin
      wb_write(ADR_LIB + WB_ADR_W'(i), WB_DAT_W'(lib[i]));
    end
  endtask

  // Start, expect busy, optionally poke start again, then poll for done
  task automatic run_engine(input logic restart_busy);
    logic [WB_DAT_W-1:0] st;
    int t0;
    wb_write(ADR_CTRL, 32'h1);
    t0 = cycle_cnt;
    wb_read(ADR_STATUS, st);
    check_status(2'b01, st);
    if (restart_busy) wb_write(ADR_CTRL, 32'h1);  // Ignored mid run
    while (!st[1]) wb_read(ADR_STATUS, st);
    check_status(2'b10, st);
    if (cycle_cnt - t0 > RUN_CYCLES + 1) begin    // Two cycle polls land within a cycle of done
      $display("Run took %0d cycles, longer than one scan", cycle_cnt - t0);
      $display("Errors found");
      $fatal(1, "Run too long");
    end
  endtask

  initial begin
    mse_t min_v;
    mse_t max_v;
    ref_t min_r;
    ref_t max_r;
    logic [WB_DAT_W-1:0] st;
    void'($urandom(SEED));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    wb_read(ADR_STATUS, st);                          // Reset values
    check_status(2'b00, st);
    read_results(min_v, min_r, max_v, max_r);
    check_mse("min_value", {MSE_W{1'b1}}, min_v);
    check_ref("min_ref", '0, min_r);
    check_mse("max_value", '0, max_v);
    check_ref("max_ref", '0, max_r);

    for (int b = 0; b < BANDS; b++) pix[b] = sample_t'($urandom);
    for (int i = 0; i < LIB_SIZE * BANDS; i++) lib[i] = sample_t'($urandom);
    load_spectra(1'b1);
    run_engine(1'b1);                                 // Random run with a restart while busy
    check_results();

    for (int b = 0; b < BANDS; b++) pix[b] = lib[3 * BANDS + b];
    load_spectra(1'b0);
    run_engine(1'b0);                                 // Exact match gives zero
    check_results();
    for (int b = 0; b < BANDS; b++) pix[b] = sample_t'($urandom);
    load_spectra(1'b0);
    run_engine(1'b0);                                 // Old zero minimum must be gone
    check_results();

    for (int b = 0; b < BANDS; b++) pix[b] = sample_t'($urandom) & 16'h7FFF;
    for (int r = 0; r < LIB_SIZE; r++) begin
      for (int b = 0; b < BANDS; b++) begin
        lib[r * BANDS + b] = pix[b] + ((r == 2 || r == 5) ? 16'd1 : sample_t'(16 * (r + 1)));
      end
    end
    load_spectra(1'b1);
    run_engine(1'b0);                                 // Entries 2 and 5 tie closest
    check_results();
    read_results(min_v, min_r, max_v, max_r);
    check_ref("min_ref", ref_t'(5), min_r);

    for (int i = BANDS; i < LIB_SIZE * BANDS; i++) lib[i] = lib[i % BANDS];
    load_spectra(1'b1);
    run_engine(1'b0);                                 // Every entry identical
    check_results();
    read_results(min_v, min_r, max_v, max_r);
    check_ref("min_ref", ref_t'(7), min_r);
    check_ref("max_ref", ref_t'(7), max_r);

    for (int b = 0; b < BANDS; b++) pix[b] = '0;
    for (int i = 0; i < LIB_SIZE * BANDS; i++) begin
      lib[i] = (i / BANDS == 4) ? 16'hFFFF : sample_t'($urandom) & 16'h0FFF;
    end
    load_spectra(1'b1);
    run_engine(1'b0);                                 // Full scale difference
    check_results();
    read_results(min_v, min_r, max_v, max_r);
    check_mse("max_value", 40'h00_FFFE_0001, max_v);
    check_ref("max_ref", ref_t'(4), max_r);

    $display("No errors");
    $finish;
  end

endmodule

// File: hsid_top.sv
module hsid_top import hsid_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat_w,
  output logic [WB_DAT_W-1:0] wb_dat_r,
  output logic                wb_ack
);

  logic    wb_req;                        // Bus cycle in progress
  logic    wb_wr;                         // Write committing this cycle
  logic    sel_pixel;                     // Pixel window hit
  logic    sel_lib;                       // Library window hit
  logic    mem_wr;
  logic    start;
  logic    run;
  logic    clear;
  logic    busy;
  logic    done;
  logic    wrap;
  sample_t pixel_q;
  sample_t lib_q;
  logic    mse_valid;
  mse_t    mse_value;
  ref_t    mse_ref;
  mse_t    min_value;
  mse_t    max_value;
  ref_t    min_ref;
  ref_t    max_ref;

  assign wb_req = wb_cyc && wb_stb;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req && !wb_ack;        // Single cycle ack one cycle after the request
    end
  end

  assign wb_wr     = wb_req && wb_ack && wb_we;
  assign sel_pixel = (wb_adr[WB_ADR_W-1:BAND_SHIFT] == ADR_PIXEL[WB_ADR_W-1:BAND_SHIFT]);
  assign sel_lib   = (wb_adr[WB_ADR_W-1:MEM_IDX_W] == ADR_LIB[WB_ADR_W-1:MEM_IDX_W]);
  assign mem_wr    = wb_wr && (sel_pixel || sel_lib);
  assign start     = wb_wr && (wb_adr == ADR_CTRL) && wb_dat_w[0];

  // Memories are write only so only results and status read back
  always_comb begin
    case (wb_adr)
      ADR_STATUS:  wb_dat_r = WB_DAT_W'({done, busy});
      ADR_MIN_LO:  wb_dat_r = min_value[WB_DAT_W-1:0];
      ADR_MIN_HI:  wb_dat_r = WB_DAT_W'(min_value[MSE_W-1:WB_DAT_W]);
      ADR_MIN_REF: wb_dat_r = WB_DAT_W'(min_ref);
      ADR_MAX_LO:  wb_dat_r = max_value[WB_DAT_W-1:0];
      ADR_MAX_HI:  wb_dat_r = WB_DAT_W'(max_value[MSE_W-1:WB_DAT_W]);
      ADR_MAX_REF: wb_dat_r = WB_DAT_W'(max_ref);
      default:     wb_dat_r = '0;         // Unmapped reads as zero
    endcase
  end

  hsid_scan_if scan_if_i ();

  hsid_band_counter band_counter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .scan  (scan_if_i.counter),
    .wrap  (wrap)
  );

  hsid_ctrl_fsm ctrl_fsm_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .wrap  (wrap),
    .run   (run),
    .clear (clear),
    .busy  (busy),
    .done  (done)
  );

  hsid_spec_mem spec_mem_i (
    .clk      (clk),
    .wr_en    (mem_wr),
    .wr_pixel (sel_pixel),
    .wr_idx   (wb_adr[MEM_IDX_W-1:0]),
    .wr_data  (wb_dat_w[SAMPLE_W-1:0]),
    .scan     (scan_if_i.spec_mem),
    .pixel_q  (pixel_q),
    .lib_q    (lib_q)
  );

  hsid_mse_calc mse_calc_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .scan      (scan_if_i.mse_calc),
    .pixel_q   (pixel_q),
    .lib_q     (lib_q),
    .mse_valid (mse_valid),
    .mse_value (mse_value),
    .mse_ref   (mse_ref)
  );

  hsid_mse_comp mse_comp_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .mse_valid (mse_valid),
    .mse_value (mse_value),
    .mse_ref   (mse_ref),
    .min_value (min_value),
    .min_ref   (min_ref),
    .max_value (max_value),
    .max_ref   (max_ref)
  );

  // Master must hold stb until it has seen ack
  a_ack_with_stb: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_ack |-> wb_cyc && wb_stb
  );

endmodule

// File: hsid_mse_comp.sv
module hsid_mse_comp import hsid_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic clear,          // Start of a new run
  input  logic mse_valid,      // New entry result
  input  mse_t mse_value,
  input  ref_t mse_ref,
  output mse_t min_value,      // Best match so far
  output ref_t min_ref,
  output mse_t max_value,      // Worst match so far
  output ref_t max_ref
);

  logic seen;                  // At least one result since clear

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      min_value <= '1;         // Any result beats all ones
      min_ref   <= '0;
      max_value <= '0;         // Any result beats zero
      max_ref   <= '0;
      seen      <= 1'b0;
    end else if (clear) begin
      min_value <= '1;
      min_ref   <= '0;
      max_value <= '0;
      max_ref   <= '0;
      seen      <= 1'b0;
    end else if (mse_valid) begin
      seen <= 1'b1;
      if (mse_value <= min_value) begin   // Ties go to the later entry
        min_value <= mse_value;
        min_ref   <= mse_ref;
      end
      if (mse_value >= max_value) begin   // Ties go to the later entry
        max_value <= mse_value;
        max_ref   <= mse_ref;
      end
    end
  end

  // Both bounds come from the same result stream
  a_min_le_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    seen |-> min_value <= max_value
  );

endmodule

// File: hsid_mse_calc.sv
module hsid_mse_calc import hsid_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  hsid_scan_if.mse_calc scan,        // Framing from the counter
  input  sample_t       pixel_q,     // Memory outputs
  input  sample_t       lib_q,
  output logic          mse_valid,   // One pulse per library entry
  output mse_t          mse_value,
  output ref_t          mse_ref
);

  // Stage 1 tags, aligned with memory data
  logic d1_en;
  logic d1_first;
  logic d1_last;
  ref_t d1_ref;

  // Stage 2 tags, aligned with the square
  logic d2_en;
  logic d2_first;
  logic d2_last;
  ref_t d2_ref;

  logic signed [SAMPLE_W:0]     diff;   // One extra bit for the sign
  logic signed [2*SAMPLE_W+1:0] prod;   // Full signed product
  mse_t sq;                             // Registered square
  mse_t acc;                            // Running sum for current entry
  mse_t sum;                            // Sum including this band

  assign diff = $signed({1'b0, pixel_q}) - $signed({1'b0, lib_q});
  assign prod = diff * diff;            // Never negative
  assign sum  = d2_first ? sq : acc + sq;   // Restart on band 0

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d1_en     <= 1'b0;
      d2_en     <= 1'b0;
      mse_valid <= 1'b0;
    end else begin
      d1_en     <= scan.en;
      d2_en     <= d1_en;
      mse_valid <= d2_en && d2_last;    // Entry complete
    end
  end

  always_ff @(posedge clk) begin
    d1_first <= scan.first_band;
    d1_last  <= scan.last_band;
    d1_ref   <= scan.ref_idx;
    d2_first <= d1_first;
    d2_last  <= d1_last;
    d2_ref   <= d1_ref;
    sq       <= MSE_W'(prod);           // Square stage
    if (d2_en) begin
      acc <= sum;                       // Accumulate stage
    end
    if (d2_en && d2_last) begin
      mse_value <= sum >> BAND_SHIFT;   // Exact mean since BANDS is a power of two
      mse_ref   <= d2_ref;
    end
  end

endmodule

// File: hsid_spec_mem.sv
module hsid_spec_mem import hsid_pkg::*; (
  input  logic                 clk,
  input  logic                 wr_en,      // Host write strobe
  input  logic                 wr_pixel,   // Target pixel array, else library
  input  logic [MEM_IDX_W-1:0] wr_idx,     // Band or ref*BANDS+band
  input  sample_t              wr_data,
  hsid_scan_if.spec_mem        scan,       // Scan read address
  output sample_t              pixel_q,    // Pixel sample, one cycle after step
  output sample_t              lib_q       // Library sample, one cycle after step
);

  sample_t pixel_mem [BANDS];              // Spectrum under test
  sample_t lib_mem   [LIB_SIZE * BANDS];   // Reference spectra, entry major

  logic [MEM_IDX_W-1:0] rd_idx;            // Flat library read address

  assign rd_idx = {scan.ref_idx, scan.band};

  // Pixel write port
  always_ff @(posedge clk) begin
    if (wr_en && wr_pixel) begin
      pixel_mem[wr_idx[BAND_SHIFT-1:0]] <= wr_data;   // Upper bits ignored
    end
  end

  // Library write port
  always_ff @(posedge clk) begin
    if (wr_en && !wr_pixel) begin
      lib_mem[wr_idx] <= wr_data;
    end
  end

  // Both arrays read in lockstep
  always_ff @(posedge clk) begin
    if (scan.en) begin
      pixel_q <= pixel_mem[scan.band];   // Same band for every entry
      lib_q   <= lib_mem[rd_idx];
    end
  end

endmodule

// File: hsid_ctrl_fsm.sv
module hsid_ctrl_fsm import hsid_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start,          // Host start pulse
  input  logic wrap,           // Counter reached final position
  output logic run,            // Counter enable
  output logic clear,          // Comparator clear
  output logic busy,           // Status busy bit
  output logic done            // Status done bit
);

  typedef enum logic [2:0] {
    S_IDLE,                    // After reset, waiting for start
    S_CLEAR,                   // One cycle comparator clear
    S_SCAN,                    // Stepping through the library
    S_DRAIN,                   // Letting the pipeline empty
    S_DONE                     // Results valid
  } state_t;

  state_t state;
  state_t state_nxt;
  logic [DRAIN_W-1:0] drain_cnt;   // Cycles spent in drain

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (start) state_nxt = S_CLEAR;
      end
      S_CLEAR: begin
        state_nxt = S_SCAN;      // Clear takes exactly one cycle
      end
      S_SCAN: begin
        if (wrap) state_nxt = S_DRAIN;
      end
      S_DRAIN: begin
        if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) state_nxt = S_DONE;
      end
      S_DONE: begin
        if (start) state_nxt = S_CLEAR;   // Restart drops done
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      drain_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == S_DRAIN) begin
        drain_cnt <= drain_cnt + 1'b1;
      end else begin
        drain_cnt <= '0;         // Rearmed for the next drain
      end
    end
  end

  assign run   = (state == S_SCAN);
  assign clear = (state == S_CLEAR);
  assign busy  = (state == S_CLEAR) || (state == S_SCAN) || (state == S_DRAIN);
  assign done  = (state == S_DONE);

  // Counter and FSM agree on when the scan ends
  a_wrap_in_scan: assert property (
    @(posedge clk) disable iff (!rst_n)
    wrap |-> state == S_SCAN
  );

endmodule

// File: hsid_band_counter.sv
module hsid_band_counter import hsid_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic run,            // Scan enable from FSM
  hsid_scan_if.counter scan,   // Scan position out
  output logic wrap            // Final position of the run
);

  band_t band_q;               // Band position
  ref_t  ref_q;                // Library position
  logic  band_end;             // Last band of an entry
  logic  ref_end;              // Last library entry

  assign band_end = (band_q == band_t'(BANDS - 1));
  assign ref_end  = (ref_q == ref_t'(LIB_SIZE - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      band_q <= '0;
      ref_q  <= '0;
    end else if (run) begin
      if (band_end) begin
        band_q <= '0;                            // Next entry starts at band 0
        ref_q  <= ref_end ? '0 : ref_q + 1'b1;   // Back to entry 0 after wrap
      end else begin
        band_q <= band_q + 1'b1;
      end
    end
  end

  assign scan.en         = run;                  // One step per run cycle
  assign scan.band       = band_q;
  assign scan.ref_idx    = ref_q;
  assign scan.first_band = (band_q == '0);
  assign scan.last_band  = band_end;
  assign wrap            = run && band_end && ref_end;

  // A scan always starts from the origin so a run never resumes midway
  a_scan_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(scan.en) |-> band_q == '0 && ref_q == '0
  );

endmodule

// File: hsid_scan_if.sv
// Scan position bus from the band counter to memory and MSE datapath
interface hsid_scan_if import hsid_pkg::*; ();

  logic  en;          // Scan step valid this cycle
  band_t band;        // Current band
  ref_t  ref_idx;     // Current library entry
  logic  first_band;  // Step is band 0 of this entry
  logic  last_band;   // Step is final band of this entry

  // Counter produces every field
  modport counter (
    output en,
    output band,
    output ref_idx,
    output first_band,
    output last_band
  );

  // Memory only needs the read address
  modport spec_mem (
    input en,
    input band,
    input ref_idx
  );

  // Datapath needs framing and the entry tag
  modport mse_calc (
    input en,
    input ref_idx,
    input first_band,
    input last_band
  );

endinterface

// File: hsid_pkg.sv
package hsid_pkg;

  // Spectrum geometry
  localparam int BANDS      = 16;                     // Bands per spectrum
  localparam int BAND_SHIFT = 4;                      // Log2 of BANDS
  localparam int LIB_SIZE   = 8;                      // Reference spectra in library
  localparam int REF_W      = $clog2(LIB_SIZE);       // Library index width
  localparam int MEM_IDX_W  = REF_W + BAND_SHIFT;     // Flat library address width

  // Datapath widths
  localparam int SAMPLE_W = 16;                       // One spectral sample
  localparam int MSE_W    = 40;                       // Accumulator with headroom

  // Run control
  localparam int DRAIN_CYCLES = 4;                    // Pipeline flush after last step
  localparam int DRAIN_W      = $clog2(DRAIN_CYCLES); // Drain counter width

  // Wishbone bus
  localparam int WB_ADR_W = 10;                       // Word address
  localparam int WB_DAT_W = 32;                       // Data bus

  // Word address map
  localparam logic [WB_ADR_W-1:0] ADR_PIXEL   = 10'h000; // Pixel bands
  localparam logic [WB_ADR_W-1:0] ADR_LIB     = 10'h100; // Library, ref*BANDS+band
  localparam logic [WB_ADR_W-1:0] ADR_CTRL    = 10'h200; // Bit 0 start
  localparam logic [WB_ADR_W-1:0] ADR_STATUS  = 10'h201; // Busy and done
  localparam logic [WB_ADR_W-1:0] ADR_MIN_LO  = 10'h202;
  localparam logic [WB_ADR_W-1:0] ADR_MIN_HI  = 10'h203;
  localparam logic [WB_ADR_W-1:0] ADR_MIN_REF = 10'h204;
  localparam logic [WB_ADR_W-1:0] ADR_MAX_LO  = 10'h205;
  localparam logic [WB_ADR_W-1:0] ADR_MAX_HI  = 10'h206;
  localparam logic [WB_ADR_W-1:0] ADR_MAX_REF = 10'h207;

  // Shared types
  typedef logic [SAMPLE_W-1:0]   sample_t;            // Spectral sample
  typedef logic [MSE_W-1:0]      mse_t;               // MSE or running sum
  typedef logic [BAND_SHIFT-1:0] band_t;              // Band index
  typedef logic [REF_W-1:0]      ref_t;               // Library index

endpackage
